// File: list.f
rtl/rv_m_pkg.sv
rtl/mult.sv
rtl/div.sv
rtl/mult_div.sv
rtl/m_exec_pipe.sv
rtl/m_result_buf.sv
rtl/m_ext_unit.sv
testbench/m_ext_checker.sv
testbench/tb_m_ext_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_m_ext_unit -f list.f -o sim_tb

status=0
out=$(./obj_dir/sim_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -q "TEST RESULT: PASS"; then
	exit 0
fi
exit 1

// File: testbench/tb_m_ext_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_m_ext_unit;

	localparam int N_TESTS    = 26;
	localparam int CLK_PERIOD = 40;
	localparam int RNG_SEED   = 32'he0332792;

	logic             clk;
	logic             arst_n;
	logic             req_valid;
	rv_m_pkg::m_req_t req;
	logic             req_credit;
	logic             res_valid;
	rv_m_pkg::m_res_t res;
	logic             res_credit;

	rv_m_pkg::funct3_e op_tbl  [N_TESTS];
	rv_m_pkg::data_t   a_tbl   [N_TESTS];
	rv_m_pkg::data_t   b_tbl   [N_TESTS];
	rv_m_pkg::data_t   exp_tbl [N_TESTS];
	int                n_loaded;

	int   results;
	int   errors;
	logic finished;

	m_ext_unit dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit)
	);

	m_ext_checker #(.N_TESTS(N_TESTS)) checker0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_credit (req_credit),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit),
		.exp_value  (exp_tbl),
		.results    (results),
		.errors     (errors),
		.finished   (finished)
	);

	task automatic add_test(input rv_m_pkg::funct3_e op, input rv_m_pkg::data_t a,
		input rv_m_pkg::data_t b, input rv_m_pkg::data_t expected);
		op_tbl[n_loaded]  = op;
		a_tbl[n_loaded]   = a;
		b_tbl[n_loaded]   = b;
		exp_tbl[n_loaded] = expected;
		n_loaded++;
	endtask

	task automatic load_table();
		n_loaded = 0;
		add_test(rv_m_pkg::MUL,    32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFEB);
		add_test(rv_m_pkg::MULH,   32'h0000_0007, 32'hFFFF_FFFD, 32'hFFFF_FFFF);
		add_test(rv_m_pkg::MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
		add_test(rv_m_pkg::MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
		add_test(rv_m_pkg::MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
		add_test(rv_m_pkg::MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
		add_test(rv_m_pkg::MULHSU, 32'h8000_0000, 32'h0000_0002, 32'hFFFF_FFFF);
		add_test(rv_m_pkg::MULHU,  32'h8000_0000, 32'h0000_0004, 32'h0000_0002);
		// Remainder keeps the dividend sign
		add_test(rv_m_pkg::DIV,    32'h0000_0064, 32'h0000_0007, 32'h0000_000E);
		add_test(rv_m_pkg::DIV,    32'hFFFF_FF9C, 32'h0000_0007, 32'hFFFF_FFF2);
		add_test(rv_m_pkg::REM,    32'hFFFF_FF9C, 32'h0000_0007, 32'hFFFF_FFFE);
		add_test(rv_m_pkg::REM,    32'h0000_0064, 32'hFFFF_FFF9, 32'h0000_0002);
		add_test(rv_m_pkg::DIV,    32'h0000_0064, 32'hFFFF_FFF9, 32'hFFFF_FFF2);
		add_test(rv_m_pkg::DIVU,   32'hFFFF_FF9C, 32'h0000_0007, 32'h2492_4916);
		add_test(rv_m_pkg::REMU,   32'hFFFF_FF9C, 32'h0000_0007, 32'h0000_0002);
		add_test(rv_m_pkg::REM,    32'hFFFF_FFF9, 32'hFFFF_FFFD, 32'hFFFF_FFFF);
		// Divide by zero
		add_test(rv_m_pkg::DIV,    32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF);
		add_test(rv_m_pkg::DIVU,   32'h0000_0005, 32'h0000_0000, 32'hFFFF_FFFF);
		add_test(rv_m_pkg::REM,    32'hFFFF_FF9C, 32'h0000_0000, 32'hFFFF_FF9C);
		add_test(rv_m_pkg::REMU,   32'hDEAD_BEEF, 32'h0000_0000, 32'hDEAD_BEEF);
		// Signed overflow and its neighbours
		add_test(rv_m_pkg::DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
		add_test(rv_m_pkg::REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
		add_test(rv_m_pkg::DIV,    32'h1000_0000, 32'hFFFF_FFFF, 32'hF000_0000);
		add_test(rv_m_pkg::DIVU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
		add_test(rv_m_pkg::REMU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
		add_test(rv_m_pkg::DIV,    32'hFFFF_FFF9, 32'hFFFF_FFFD, 32'h0000_0002);
	endtask

	// Issue whenever an upstream credit is held
	task automatic issue_all();
		int idx;
		int credits;
		idx     = 0;
		credits = rv_m_pkg::RES_DEPTH;
		while (idx < N_TESTS) begin
			@(negedge clk);
			if (req_credit)
				credits++;
			if (credits > 0) begin
				req_valid  = 1'b1;
				req.funct3 = op_tbl[idx];
				req.a      = a_tbl[idx];
				req.b      = b_tbl[idx];
				req.tag    = rv_m_pkg::TAG_W'(idx % 16);
				credits--;
				idx++;
			end else begin
				req_valid = 1'b0;
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		arst_n    = 1'b0;
		req_valid = 1'b0;
		req       = '0;
		load_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		issue_all();
		wait (finished === 1'b1);
		$display("%0d tests, %0d results, %0d errors", N_TESTS, results, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Downstream grants with random gaps, at most four outstanding
	initial begin : grant_credits
		int granted;
		int gap;
		res_credit = 1'b0;
		granted    = 0;
		void'($urandom(RNG_SEED));
		wait (arst_n === 1'b1);
		repeat (20) @(negedge clk);
		while (granted < N_TESTS) begin
			gap = $urandom % 6;
			repeat (gap) @(negedge clk);
			@(negedge clk);
			if (granted - results < 4) begin
				res_credit = 1'b1;
				granted++;
				@(negedge clk);
				res_credit = 1'b0;
			end
		end
	end

	initial begin
		#(N_TESTS * 40 * CLK_PERIOD);
		$display("timeout: results still missing after %0d ns", N_TESTS * 40 * CLK_PERIOD);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/m_ext_checker.sv
`timescale 1ns/1ns
`default_nettype none

module m_ext_checker #(
	parameter int N_TESTS = 1
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             req_credit,
	input  logic             res_valid,
	input  rv_m_pkg::m_res_t res,
	input  logic             res_credit,
	input  rv_m_pkg::data_t  exp_value [N_TESTS],
	output int               results,
	output int               errors,
	output logic             finished
);

	int   granted;
	int   returned;
	int   drain;
	logic popped;

	task automatic check_beat();
		logic [rv_m_pkg::TAG_W-1:0] exp_tag;
		int                         errs_before;
		exp_tag     = rv_m_pkg::TAG_W'(results % 16);
		errs_before = errors;
		if (results >= granted) begin
			$display("error at %0t: result sent without a downstream credit", $time);
			errors++;
		end
		if (results >= N_TESTS) begin
			$display("error at %0t: more results than requests were issued", $time);
			errors++;
		end else begin
			if (res.tag !== exp_tag) begin
				$display("mismatch at %0t: res.tag got %0d expected %0d",
					$time, res.tag, exp_tag);
				errors++;
			end
			if (res.value !== exp_value[results]) begin
				$display("mismatch at %0t: res.value got %h expected %h",
					$time, res.value, exp_value[results]);
				errors++;
			end
			$display("test %0d: tag %0d value %h %s", results, res.tag, res.value,
				(errors == errs_before) ? "ok" : "failed");
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			results  = 0;
			errors   = 0;
			finished = 1'b0;
			granted  = 0;
			returned = 0;
			drain    = 0;
			popped   = 1'b0;
		end else if (!finished) begin
			// Credit pulse belongs to a pop at an earlier edge
			if (req_credit) begin
				returned = returned + 1;
				if (returned > results) begin
					$display("error at %0t: upstream credit returned with no result sent",
						$time);
					errors = errors + 1;
				end
			end
			// Exactly one cycle after each pop
			if (req_credit !== popped) begin
				$display("error at %0t: upstream credit pulse not one cycle after a result",
					$time);
				errors = errors + 1;
			end
			popped = res_valid;
			if (res_valid) begin
				check_beat();
				results = results + 1;
			end
			if (res_credit)
				granted = granted + 1;
			// Let the last upstream credit come back before the final count
			if (results >= N_TESTS) begin
				drain = drain + 1;
				if (drain == 3) begin
					if (returned != results) begin
						$display("error: %0d upstream credits returned for %0d results",
							returned, results);
						errors = errors + 1;
					end
					finished = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/m_ext_unit.sv
`timescale 1ns/1ns
`default_nettype none

module m_ext_unit (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              req_valid,
	input  rv_m_pkg::m_req_t  req,
	output logic              req_credit,

	output logic              res_valid,
	output rv_m_pkg::m_res_t  res,
	input  logic              res_credit
);

	logic             pipe_valid;
	rv_m_pkg::m_res_t pipe_res;

	// Fixed two cycle arithmetic, never stalls
	m_exec_pipe exec_pipe0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.pipe_valid (pipe_valid),
		.pipe_res   (pipe_res)
	);

	// Absorbs downstream back-pressure
	m_result_buf result_buf0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.pipe_valid (pipe_valid),
		.pipe_res   (pipe_res),
		.res_valid  (res_valid),
		.res        (res),
		.res_credit (res_credit),
		.req_credit (req_credit)
	);

endmodule

`default_nettype wire

// File: rtl/m_result_buf.sv
`timescale 1ns/1ns
`default_nettype none

module m_result_buf (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              pipe_valid,
	input  rv_m_pkg::m_res_t  pipe_res,

	output logic              res_valid,
	output rv_m_pkg::m_res_t  res,
	input  logic              res_credit,
	output logic              req_credit
);

	rv_m_pkg::m_res_t mem [rv_m_pkg::RES_DEPTH];

	logic [$clog2(rv_m_pkg::RES_DEPTH)-1:0] wr_ptr;
	logic [$clog2(rv_m_pkg::RES_DEPTH)-1:0] rd_ptr;
	logic [rv_m_pkg::CNT_W-1:0]             fill;
	logic [rv_m_pkg::CNT_W-1:0]             ds_credit;

	// Send only with a held entry and a downstream credit
	assign res_valid = (fill != '0) && (ds_credit != '0);
	assign res       = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (pipe_valid)
			mem[wr_ptr] <= pipe_res;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			ds_credit  <= '0;
			req_credit <= 1'b0;
		end else begin
			if (pipe_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (res_valid)
				rd_ptr <= rd_ptr + 1'b1;
			fill       <= fill + pipe_valid - res_valid;
			ds_credit  <= ds_credit + res_credit - res_valid;
			// Slot freed, hand one credit back upstream
			req_credit <= res_valid;
		end
	end

	a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
		pipe_valid |-> (fill != rv_m_pkg::CNT_W'(rv_m_pkg::RES_DEPTH)));

	a_credit_no_ovf: assert property (@(posedge clk) disable iff (!arst_n)
		(res_credit && !res_valid) |-> (ds_credit != '1));

endmodule

`default_nettype wire

// File: rtl/m_exec_pipe.sv
`timescale 1ns/1ns
`default_nettype none

module m_exec_pipe (
	input  logic              clk,
	input  logic              arst_n,

	input  logic              req_valid,
	input  rv_m_pkg::m_req_t  req,

	output logic              pipe_valid,
	output rv_m_pkg::m_res_t  pipe_res
);

	rv_m_pkg::m_req_t req_q;
	logic             valid_q;
	rv_m_pkg::data_t  c_out;

	// Operand stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		req_q <= req;
	end

	mult_div mult_div0 (
		.funct3 (req_q.funct3),
		.a_in   (req_q.a),
		.b_in   (req_q.b),
		.c_out  (c_out)
	);

	// Result stage carries the tag along
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pipe_valid <= 1'b0;
		end else begin
			pipe_valid <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		pipe_res.value <= c_out;
		pipe_res.tag   <= req_q.tag;
	end

	a_funct3_known: assert property (@(posedge clk) disable iff (!arst_n)
		valid_q |-> !$isunknown(req_q.funct3));

endmodule

`default_nettype wire

// File: rtl/mult_div.sv
`timescale 1ns/1ns
`default_nettype none

module mult_div (
	input  rv_m_pkg::funct3_e funct3,
	input  rv_m_pkg::data_t   a_in,
	input  rv_m_pkg::data_t   b_in,

	output rv_m_pkg::data_t   c_out
);

	logic a_signed;
	logic b_signed;

	logic [rv_m_pkg::EXT_W-1:0]   a_ext;
	logic [rv_m_pkg::EXT_W-1:0]   b_ext;
	logic [2*rv_m_pkg::EXT_W-1:0] product;
	logic [rv_m_pkg::EXT_W-1:0]   quotient;
	logic [rv_m_pkg::EXT_W-1:0]   remain;

	logic div_zero;
	logic div_ovf;

	// MULHSU takes signed rs1 and unsigned rs2
	always_comb begin
		unique case (funct3)
			rv_m_pkg::MULHU,
			rv_m_pkg::DIVU,
			rv_m_pkg::REMU:   a_signed = 1'b0;
			default:          a_signed = 1'b1;
		endcase
	end

	always_comb begin
		unique case (funct3)
			rv_m_pkg::MUL,
			rv_m_pkg::MULH,
			rv_m_pkg::DIV,
			rv_m_pkg::REM:    b_signed = 1'b1;
			default:          b_signed = 1'b0;
		endcase
	end

	assign a_ext = {{(rv_m_pkg::EXT_W-rv_m_pkg::XLEN){a_signed & a_in[rv_m_pkg::XLEN-1]}}, a_in};
	assign b_ext = {{(rv_m_pkg::EXT_W-rv_m_pkg::XLEN){b_signed & b_in[rv_m_pkg::XLEN-1]}}, b_in};

	mult mult0 (
		.a       (a_ext),
		.b       (b_ext),
		.product (product)
	);

	div div0 (
		.numer    (a_ext),
		.denom    (b_ext),
		.quotient (quotient),
		.remain   (remain)
	);

	// Corner cases per the M extension spec
	assign div_zero = (b_in == '0);
	assign div_ovf  = (a_in == {1'b1, {(rv_m_pkg::XLEN-1){1'b0}}}) && (b_in == '1);

	always_comb begin
		unique case (funct3)
			rv_m_pkg::MUL:    c_out = product[rv_m_pkg::XLEN-1:0];
			rv_m_pkg::MULH,
			rv_m_pkg::MULHSU,
			rv_m_pkg::MULHU:  c_out = product[2*rv_m_pkg::XLEN-1:rv_m_pkg::XLEN];
			rv_m_pkg::DIV: begin
				if (div_zero)
					c_out = '1;
				else if (div_ovf)
					c_out = a_in;
				else
					c_out = quotient[rv_m_pkg::XLEN-1:0];
			end
			rv_m_pkg::DIVU: begin
				if (div_zero)
					c_out = '1;
				else
					c_out = quotient[rv_m_pkg::XLEN-1:0];
			end
			rv_m_pkg::REM: begin
				if (div_zero)
					c_out = a_in;
				else if (div_ovf)
					c_out = '0;
				else
					c_out = remain[rv_m_pkg::XLEN-1:0];
			end
			rv_m_pkg::REMU: begin
				if (div_zero)
					c_out = a_in;
				else
					c_out = remain[rv_m_pkg::XLEN-1:0];
			end
			default:          c_out = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/div.sv
`timescale 1ns/1ns
`default_nettype none

module div (
	input  logic [rv_m_pkg::EXT_W-1:0] numer,
	input  logic [rv_m_pkg::EXT_W-1:0] denom,

	output logic [rv_m_pkg::EXT_W-1:0] quotient,
	output logic [rv_m_pkg::EXT_W-1:0] remain
);

	logic [rv_m_pkg::EXT_W-1:0] n_mag;
	logic [rv_m_pkg::EXT_W-1:0] d_mag;
	logic [rv_m_pkg::EXT_W-1:0] q_mag;
	logic [rv_m_pkg::EXT_W-1:0] rem_chain [0:rv_m_pkg::EXT_W];

	assign n_mag = numer[rv_m_pkg::EXT_W-1] ? -numer : numer;
	assign d_mag = denom[rv_m_pkg::EXT_W-1] ? -denom : denom;

	assign rem_chain[0] = '0;

	// One restoring step per quotient bit, MSB first
	for (genvar i = 0; i < rv_m_pkg::EXT_W; i++) begin : g_stage
		logic [rv_m_pkg::EXT_W:0] trial;
		logic [rv_m_pkg::EXT_W:0] diff;

		assign trial = {rem_chain[i], n_mag[rv_m_pkg::EXT_W-1-i]};
		assign diff  = trial - {1'b0, d_mag};
		assign q_mag[rv_m_pkg::EXT_W-1-i] = (trial >= {1'b0, d_mag});
		assign rem_chain[i+1] = q_mag[rv_m_pkg::EXT_W-1-i] ?
			diff[rv_m_pkg::EXT_W-1:0] : trial[rv_m_pkg::EXT_W-1:0];
	end

	// Remainder follows the dividend sign
	assign quotient = (numer[rv_m_pkg::EXT_W-1] ^ denom[rv_m_pkg::EXT_W-1]) ? -q_mag : q_mag;
	assign remain   = numer[rv_m_pkg::EXT_W-1] ?
		-rem_chain[rv_m_pkg::EXT_W] : rem_chain[rv_m_pkg::EXT_W];

endmodule

`default_nettype wire

// File: rtl/mult.sv
`timescale 1ns/1ns
`default_nettype none

module mult (
	input  logic [rv_m_pkg::EXT_W-1:0]   a,
	input  logic [rv_m_pkg::EXT_W-1:0]   b,

	output logic [2*rv_m_pkg::EXT_W-1:0] product
);

	logic [2*rv_m_pkg::EXT_W-1:0] a_wide;

	assign a_wide = {{rv_m_pkg::EXT_W{a[rv_m_pkg::EXT_W-1]}}, a};

	// Top bit of b has negative weight, so that row is subtracted
	always_comb begin
		product = '0;
		for (int i = 0; i < rv_m_pkg::EXT_W; i++) begin
			if (b[i]) begin
				if (i == rv_m_pkg::EXT_W-1)
					product = product - (a_wide << i);
				else
					product = product + (a_wide << i);
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/rv_m_pkg.sv
`default_nettype none

package rv_m_pkg;

	localparam int XLEN = 32;

	// Operands widened past XLEN so unsigned values stay positive
	localparam int EXT_W = 40;

	localparam int TAG_W = 4;

	// Result buffer slots, also the upstream credits after reset
	localparam int RES_DEPTH = 4;
	localparam int CNT_W = 3;

	typedef logic [XLEN-1:0] data_t;

	typedef enum logic [2:0] {
		MUL    = 3'b000,
		MULH   = 3'b001,
		MULHSU = 3'b010,
		MULHU  = 3'b011,
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} funct3_e;

	typedef struct packed {
		funct3_e           funct3;
		data_t             a;
		data_t             b;
		logic [TAG_W-1:0]  tag;
	} m_req_t;

	typedef struct packed {
		data_t             value;
		logic [TAG_W-1:0]  tag;
	} m_res_t;

endpackage

`default_nettype wire
